/* ls_defines.svh */
`ifndef LS_DEFINES_SVH
`define LS_DEFINES_SVH

//////////////////////////////////////////////////
// load/store array sizing
//////////////////////////////////////////////////

// one lane carries a full fifo word
`define LS_WORD_W     64

// activation lanes toward the matrix unit
`define LS_COLUMNS    8

// weight lanes and result lanes
`define LS_ROWS       8

// weight memory depth in words
`define LS_WMEM_SIZE  64
`define LS_WADDR_W    32

// lane index with one spare bit so a counter can hold the lane count itself
// columns and rows share this width
`define LS_IDX_W      ($clog2(`LS_COLUMNS) + 1)

`endif

/* ls_pkg.sv */
`include "ls_defines.svh"

package ls_pkg;

    // precision of the packed operands, each step doubles the bit count
    typedef enum logic [1:0] {
        PREC_INT8  = 2'd0,
        PREC_INT16 = 2'd1,
        PREC_INT32 = 2'd2,
        PREC_INT64 = 2'd3
    } precision_e;

    typedef logic [`LS_WORD_W-1:0] word_t;

    // lane vectors, lane 0 in the low word
    typedef word_t [`LS_COLUMNS-1:0] col_vec_t;
    typedef word_t [`LS_ROWS-1:0]    row_vec_t;

    // one enable bit per lane
    typedef logic [`LS_COLUMNS-1:0] col_mask_t;
    typedef logic [`LS_ROWS-1:0]    row_mask_t;

    typedef logic [`LS_IDX_W-1:0] lane_idx_t;

    // strobes from the control unit
    typedef struct packed {
        logic enable_load_array;
        logic infifo_read;
        logic outfifo_write;
        logic read_weight_memory;
        logic load_activation;
        logic store_activation;
    } array_ctrl_t;

    // counter configuration, shared by the slot and the weight counter
    typedef struct packed {
        logic      enable;
        logic      ld_max;
        lane_idx_t max_value;
    } cnt_cfg_t;

endpackage

/* lane_enable_decoder.sv */
`timescale 1ns/1ps

`include "ls_defines.svh"

module lane_enable_decoder import ls_pkg::*; (
    input  precision_e precision,
    input  logic       enable_load_array,
    output col_mask_t  col_mask,
    output row_mask_t  row_mask
);

    int col_active;
    int row_active;

    // lanes in use = lane count * operand bits / word bits
    function automatic int active_lanes(input int lane_count, input precision_e prec);
        return (lane_count * (8 << int'(prec))) / `LS_WORD_W;
    endfunction

    assign col_active = active_lanes(`LS_COLUMNS, precision);
    assign row_active = active_lanes(`LS_ROWS, precision);

    //////////////////////////////////////////////////
    // thermometer masks, unused lanes never switch
    //////////////////////////////////////////////////
    always_comb begin
        col_mask = '0;
        row_mask = '0;
        if (enable_load_array) begin
            for (int i = 0; i < `LS_COLUMNS; i++) begin
                col_mask[i] = (i < col_active);
            end
            for (int i = 0; i < `LS_ROWS; i++) begin
                row_mask[i] = (i < row_active);
            end
        end
    end

endmodule

/* slot_counter.sv */
`timescale 1ns/1ps

`include "ls_defines.svh"

module slot_counter import ls_pkg::*; (
    input  logic      clk,
    input  logic      reset_n,
    input  logic      enable_load_array,
    input  cnt_cfg_t  cfg,
    output lane_idx_t slot
);

    lane_idx_t          max_cnt;
    logic [`LS_IDX_W:0] slot_inc;

    // one extra bit so the compare holds even at the top of the range
    assign slot_inc = slot + 1'b1;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            slot    <= '0;
            max_cnt <= '0;
        end else if (enable_load_array) begin
            if (cfg.ld_max) begin
                max_cnt <= cfg.max_value;
            end
            if (cfg.enable) begin
                // wrap after max - 1
                if (slot_inc >= {1'b0, max_cnt}) begin
                    slot <= '0;
                end else begin
                    slot <= slot_inc[`LS_IDX_W-1:0];
                end
            end else begin
                slot <= '0;
            end
        end
    end

endmodule

/* lane_load_bank.sv */
`timescale 1ns/1ps

`include "ls_defines.svh"

module lane_load_bank import ls_pkg::*; #(
    parameter int LANES = `LS_COLUMNS
) (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic [LANES-1:0]       lane_mask,
    input  logic                   write,
    input  lane_idx_t              lane_sel,
    input  word_t                  data_in,
    output word_t [LANES-1:0]      lanes
);

    logic [LANES-1:0] lane_we;

    //////////////////////////////////////////////////
    // scatter, one lane per write strobe
    //////////////////////////////////////////////////

    // an index past the last lane matches nothing and is dropped
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            lane_we[i] = write && lane_mask[i] && (lane_sel == lane_idx_t'(i));
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            lanes <= '0;
        end else begin
            for (int i = 0; i < LANES; i++) begin
                // unselected lanes keep their word
                if (lane_we[i]) begin
                    lanes[i] <= data_in;
                end
            end
        end
    end

endmodule

/* result_bank.sv */
`timescale 1ns/1ps

`include "ls_defines.svh"

module result_bank import ls_pkg::*; (
    input  logic      clk,
    input  logic      reset_n,
    input  row_mask_t row_mask,
    input  logic      store,
    input  row_vec_t  results,
    input  logic      outfifo_write,
    input  lane_idx_t slot,
    output word_t     fifo_out_data
);

    localparam int LANE_BITS = $clog2(`LS_ROWS);

    row_vec_t stored;

    //////////////////////////////////////////////////
    // parallel capture of the matrix unit results
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            stored <= '0;
        end else if (store) begin
            for (int i = 0; i < `LS_ROWS; i++) begin
                if (row_mask[i]) begin
                    stored[i] <= results[i];
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // gather one lane toward the output fifo
    //////////////////////////////////////////////////
    always_comb begin
        fifo_out_data = '0;
        // slot values past the last row give zero
        if (outfifo_write && (slot < `LS_ROWS)) begin
            fifo_out_data = stored[slot[LANE_BITS-1:0]];
        end
    end

endmodule

/* weight_address_gen.sv */
`timescale 1ns/1ps

`include "ls_defines.svh"

module weight_address_gen import ls_pkg::*; (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   enable_load_array,
    input  cnt_cfg_t               cfg,
    output lane_idx_t              weight_idx,
    output logic [`LS_WADDR_W-1:0] wm_address,
    output logic                   weight_row_done
);

    localparam int LANE_BITS = $clog2(`LS_ROWS);
    localparam int PAGE_W    = `LS_WADDR_W - LANE_BITS;

    lane_idx_t              max_cnt;
    logic [PAGE_W-1:0]      page;
    logic [PAGE_W-1:0]      page_inc;
    logic [`LS_IDX_W:0]     idx_inc;
    logic [`LS_WADDR_W-1:0] full_address;
    logic [`LS_WADDR_W-1:0] next_page_base;

    assign idx_inc        = weight_idx + 1'b1;
    assign page_inc       = page + 1'b1;
    // page in the upper bits, lane index below
    assign full_address   = {page, weight_idx[LANE_BITS-1:0]};
    assign next_page_base = {page_inc, {LANE_BITS{1'b0}}};

    //////////////////////////////////////////////////
    // lane index and page counters
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            max_cnt         <= '0;
            weight_idx      <= '0;
            page            <= '0;
            weight_row_done <= 1'b0;
        end else begin
            weight_row_done <= 1'b0;
            if (enable_load_array) begin
                if (cfg.ld_max) begin
                    max_cnt <= cfg.max_value;
                end
                if (cfg.enable) begin
                    if (idx_inc >= {1'b0, max_cnt}) begin
                        weight_idx      <= '0;
                        weight_row_done <= 1'b1;
                        // a short row may never touch the last word, so the page
                        // also wraps once the next one starts outside the memory
                        if (next_page_base >= `LS_WMEM_SIZE) begin
                            page <= '0;
                        end else begin
                            page <= page_inc;
                        end
                    end else begin
                        weight_idx <= idx_inc[`LS_IDX_W-1:0];
                    end
                    // last memory word, start over
                    if (full_address == `LS_WMEM_SIZE - 1) begin
                        weight_idx <= '0;
                        page       <= '0;
                    end
                end
            end
        end
    end

    assign wm_address = cfg.enable ? full_address : '0;

endmodule

/* ls_array.sv */
`timescale 1ns/1ps

`include "ls_defines.svh"

module ls_array import ls_pkg::*; (
    input  logic                   clk,
    input  logic                   reset_n,
    input  precision_e             precision,
    input  array_ctrl_t            ctrl,
    input  cnt_cfg_t               slot_cfg,
    input  cnt_cfg_t               weight_cfg,
    input  word_t                  fifo_in_data,
    input  word_t                  weight_mem_data,
    input  row_vec_t               mxu_results,
    output word_t                  fifo_out_data,
    output col_vec_t               mxu_activations,
    output row_vec_t               mxu_weights,
    output logic [`LS_WADDR_W-1:0] wm_address,
    output logic                   weight_row_done
);

    col_mask_t col_mask;
    row_mask_t row_mask;
    lane_idx_t slot;
    lane_idx_t weight_idx;
    logic      act_write;

    assign act_write = ctrl.infifo_read & ctrl.load_activation;

    //////////////////////////////////////////////////
    // lane enables and counters
    //////////////////////////////////////////////////
    lane_enable_decoder lane_dec (
        .precision         (precision),
        .enable_load_array (ctrl.enable_load_array),
        .col_mask          (col_mask),
        .row_mask          (row_mask)
    );

    slot_counter slot_cnt (
        .clk               (clk),
        .reset_n           (reset_n),
        .enable_load_array (ctrl.enable_load_array),
        .cfg               (slot_cfg),
        .slot              (slot)
    );

    // the weight index also steers the weight scatter
    weight_address_gen waddr_gen (
        .clk               (clk),
        .reset_n           (reset_n),
        .enable_load_array (ctrl.enable_load_array),
        .cfg               (weight_cfg),
        .weight_idx        (weight_idx),
        .wm_address        (wm_address),
        .weight_row_done   (weight_row_done)
    );

    //////////////////////////////////////////////////
    // activation, weight and result lanes
    //////////////////////////////////////////////////
    lane_load_bank #(.LANES(`LS_COLUMNS)) act_bank (
        .clk       (clk),
        .reset_n   (reset_n),
        .lane_mask (col_mask),
        .write     (act_write),
        .lane_sel  (slot),
        .data_in   (fifo_in_data),
        .lanes     (mxu_activations)
    );

    lane_load_bank #(.LANES(`LS_ROWS)) weight_bank (
        .clk       (clk),
        .reset_n   (reset_n),
        .lane_mask (row_mask),
        .write     (ctrl.read_weight_memory),
        .lane_sel  (weight_idx),
        .data_in   (weight_mem_data),
        .lanes     (mxu_weights)
    );

    result_bank res_bank (
        .clk           (clk),
        .reset_n       (reset_n),
        .row_mask      (row_mask),
        .store         (ctrl.store_activation),
        .results       (mxu_results),
        .outfifo_write (ctrl.outfifo_write),
        .slot          (slot),
        .fifo_out_data (fifo_out_data)
    );

endmodule

/* ls_array_properties.sv */
`timescale 1ns/1ps

`include "ls_defines.svh"

module ls_array_properties import ls_pkg::*; (
    input logic                   clk,
    input logic                   reset_n,
    input array_ctrl_t            ctrl,
    input cnt_cfg_t               slot_cfg,
    input cnt_cfg_t               weight_cfg,
    input lane_idx_t              slot,
    input lane_idx_t              weight_idx,
    input word_t                  fifo_out_data,
    input logic [`LS_WADDR_W-1:0] wm_address
);

    int        fail_count = 0;
    lane_idx_t slot_max;
    lane_idx_t weight_max;

    // shadow copies of the maxima held inside the counters
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            slot_max   <= '0;
            weight_max <= '0;
        end else if (ctrl.enable_load_array) begin
            if (slot_cfg.ld_max) begin
                slot_max <= slot_cfg.max_value;
            end
            if (weight_cfg.ld_max) begin
                weight_max <= weight_cfg.max_value;
            end
        end
    end

    //////////////////////////////////////////////////
    // idle outputs and counter ranges
    //////////////////////////////////////////////////
    address_idle: assert property (@(posedge clk) disable iff (!reset_n)
        !weight_cfg.enable |-> wm_address == '0)
    else begin
        fail_count++;
        $error("wm_address is not zero while the weight counter is off");
    end

    gather_idle: assert property (@(posedge clk) disable iff (!reset_n)
        !ctrl.outfifo_write |-> fifo_out_data == '0)
    else begin
        fail_count++;
        $error("fifo_out_data is not zero without an output fifo write");
    end

    slot_range: assert property (@(posedge clk) disable iff (!reset_n)
        slot_max != '0 |-> slot < slot_max)
    else begin
        fail_count++;
        $error("slot counter ran past its loaded maximum");
    end

    weight_idx_range: assert property (@(posedge clk) disable iff (!reset_n)
        weight_max != '0 |-> weight_idx < weight_max)
    else begin
        fail_count++;
        $error("weight index ran past its loaded maximum");
    end

endmodule

bind ls_array ls_array_properties props_i (
    .clk           (clk),
    .reset_n       (reset_n),
    .ctrl          (ctrl),
    .slot_cfg      (slot_cfg),
    .weight_cfg    (weight_cfg),
    .slot          (slot),
    .weight_idx    (weight_idx),
    .fifo_out_data (fifo_out_data),
    .wm_address    (wm_address)
);

/* tb_ls_array.sv */
`timescale 1ns/1ps

`include "ls_defines.svh"

module tb_ls_array import ls_pkg::*; ();

    typedef enum logic [1:0] {
        OP_LOAD   = 2'd0,
        OP_STORE  = 2'd1,
        OP_GATHER = 2'd2,
        OP_WEIGHT = 2'd3
    } op_e;

    // record layout: opcode, precision, step count, data word, expected word
    localparam int FIELDS     = 5;
    localparam int MAX_RECS   = 64;
    localparam int SLOT_MAX   = 8;
    localparam int WEIGHT_MAX = 4;

    logic                   clk = 1'b0;
    logic                   reset_n;
    precision_e             precision;
    array_ctrl_t            ctrl;
    cnt_cfg_t               slot_cfg;
    cnt_cfg_t               weight_cfg;
    word_t                  fifo_in_data;
    word_t                  weight_mem_data;
    row_vec_t               mxu_results;
    word_t                  fifo_out_data;
    col_vec_t               mxu_activations;
    row_vec_t               mxu_weights;
    logic [`LS_WADDR_W-1:0] wm_address;
    logic                   weight_row_done;

    logic [63:0] recs [0:FIELDS*MAX_RECS-1];
    int          cycles      = 0;
    int          cycle_limit = 100000;
    logic [63:0] lcg_state   = 64'd7;

    // reference model of the lane registers and both counters
    col_vec_t act_model;
    row_vec_t wgt_model;
    row_vec_t res_model;
    int       slot_m;
    int       widx_m;
    int       page_m;
    logic     done_m;

    ls_array dut_i (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout, the test did not finish within %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $fatal(1);
        end
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////
    function automatic word_t next_filler();
        lcg_state = lcg_state * 64'd6364136223846793005 + 64'd1442695040888963407;
        return lcg_state;
    endfunction

    // lanes in use double with each precision step
    function automatic int used_lanes(input precision_e prec);
        return 1 << int'(prec);
    endfunction

    task automatic check_word(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
        assert (actual === expected) else begin
            $display("ERROR at %0t ns, %s expected %h, got %h", $time, name, expected, actual);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_state();
        for (int i = 0; i < `LS_COLUMNS; i++) begin
            check_word($sformatf("mxu_activations[%0d]", i), mxu_activations[i], act_model[i]);
        end
        for (int i = 0; i < `LS_ROWS; i++) begin
            check_word($sformatf("mxu_weights[%0d]", i), mxu_weights[i], wgt_model[i]);
        end
        check_word("weight_row_done", weight_row_done, done_m);
        check_word("bound assertion failures", dut_i.props_i.fail_count, 0);
    endtask

    task automatic drive_idle();
        ctrl              = '0;
        slot_cfg.enable   = 1'b0;
        slot_cfg.ld_max   = 1'b0;
        weight_cfg.enable = 1'b0;
        weight_cfg.ld_max = 1'b0;
        // noise on the data inputs, nothing is strobed
        fifo_in_data    = next_filler();
        weight_mem_data = next_filler();
        for (int i = 0; i < `LS_ROWS; i++) begin
            mxu_results[i] = next_filler();
        end
    endtask

    // model update for one active clock edge
    task automatic model_edge(input op_e op, input precision_e prec, input word_t word);
        int n;
        int addr;
        n      = used_lanes(prec);
        addr   = page_m * `LS_ROWS + widx_m;
        done_m = 1'b0;
        case (op)
            OP_LOAD: begin
                if (slot_m < n) begin
                    act_model[slot_m] = word;
                end
            end
            OP_STORE: begin
                for (int i = 0; i < n; i++) begin
                    res_model[i] = word + i;
                end
            end
            OP_WEIGHT: begin
                if (widx_m < n) begin
                    wgt_model[widx_m] = word;
                end
                if (widx_m + 1 >= WEIGHT_MAX) begin
                    widx_m = 0;
                    done_m = 1'b1;
                    page_m = ((page_m + 1) * `LS_ROWS >= `LS_WMEM_SIZE) ? 0 : page_m + 1;
                end else begin
                    widx_m++;
                end
                if (addr == `LS_WMEM_SIZE - 1) begin
                    widx_m = 0;
                    page_m = 0;
                end
            end
            default: ;
        endcase
        // any active cycle without the slot enable clears the slot
        if (op == OP_LOAD || op == OP_GATHER) begin
            slot_m = (slot_m + 1 >= SLOT_MAX) ? 0 : slot_m + 1;
        end else begin
            slot_m = 0;
        end
    endtask

    task automatic run_step(input op_e op, input precision_e prec, input word_t word,
                            output word_t observed);
        int          lane;
        word_t       exp_out;
        logic [63:0] exp_addr;
        @(negedge clk);
        lane                   = slot_m;
        precision              = prec;
        ctrl.enable_load_array = 1'b1;
        case (op)
            OP_LOAD: begin
                ctrl.infifo_read     = 1'b1;
                ctrl.load_activation = 1'b1;
                slot_cfg.enable      = 1'b1;
                fifo_in_data         = word;
            end
            OP_STORE: begin
                ctrl.store_activation = 1'b1;
                for (int i = 0; i < `LS_ROWS; i++) begin
                    mxu_results[i] = word + i;
                end
            end
            OP_GATHER: begin
                ctrl.outfifo_write = 1'b1;
                slot_cfg.enable    = 1'b1;
            end
            default: begin
                ctrl.read_weight_memory = 1'b1;
                weight_cfg.enable       = 1'b1;
                weight_mem_data         = word;
            end
        endcase
        // combinational outputs, sampled mid cycle
        #2;
        exp_out  = (op == OP_GATHER && slot_m < `LS_ROWS) ? res_model[slot_m] : '0;
        exp_addr = (op == OP_WEIGHT) ? 64'(page_m * `LS_ROWS + widx_m) : 64'd0;
        check_word("fifo_out_data", fifo_out_data, exp_out);
        check_word("wm_address", wm_address, exp_addr);
        observed = (op == OP_WEIGHT) ? 64'(wm_address) : fifo_out_data;
        model_edge(op, prec, word);
        @(negedge clk);
        check_state();
        if (op == OP_LOAD) begin
            observed = mxu_activations[lane];
        end
        drive_idle();
        #2;
        check_word("fifo_out_data", fifo_out_data, 0);
        check_word("wm_address", wm_address, 0);
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////
    initial begin
        int         n_recs;
        int         steps;
        int         count;
        op_e        op;
        precision_e prec;
        word_t      word;
        word_t      expected;
        word_t      observed;
        string      name;

        for (int i = 0; i < FIELDS * MAX_RECS; i++) begin
            recs[i] = '1;
        end
        $readmemh("ls_array_input.txt", recs);
        n_recs = 0;
        steps  = 0;
        while (n_recs < MAX_RECS && recs[n_recs * FIELDS] != '1) begin
            steps += int'(recs[n_recs * FIELDS + 2]);
            n_recs++;
        end
        cycle_limit = steps * 12 + 50;
        assert (n_recs > 0) else begin
            $display("no stimulus records were found in ls_array_input.txt");
            $display("TEST FAILED");
            $fatal(1);
        end

        reset_n         = 1'b0;
        precision       = PREC_INT64;
        ctrl            = '0;
        slot_cfg        = '0;
        weight_cfg      = '0;
        fifo_in_data    = '0;
        weight_mem_data = '0;
        mxu_results     = '0;
        act_model       = '0;
        wgt_model       = '0;
        res_model       = '0;
        slot_m          = 0;
        widx_m          = 0;
        page_m          = 0;
        done_m          = 1'b0;
        repeat (2) @(negedge clk);
        reset_n = 1'b1;
        check_state();
        check_word("fifo_out_data", fifo_out_data, 0);
        check_word("wm_address", wm_address, 0);

        // load both maxima while the counters stay at zero
        ctrl.enable_load_array = 1'b1;
        slot_cfg   = '{enable: 1'b0, ld_max: 1'b1, max_value: lane_idx_t'(SLOT_MAX)};
        weight_cfg = '{enable: 1'b0, ld_max: 1'b1, max_value: lane_idx_t'(WEIGHT_MAX)};
        @(negedge clk);
        drive_idle();

        for (int r = 0; r < n_recs; r++) begin
            op       = op_e'(recs[r * FIELDS][1:0]);
            prec     = precision_e'(recs[r * FIELDS + 1][1:0]);
            count    = int'(recs[r * FIELDS + 2]);
            word     = recs[r * FIELDS + 3];
            expected = recs[r * FIELDS + 4];
            for (int k = 0; k < count; k++) begin
                // weight words come from the filler generator
                run_step(op, prec, (op == OP_WEIGHT) ? next_filler() : word + k, observed);
            end
            if (op == OP_WEIGHT) begin
                name = "wm_address";
            end else if (op == OP_LOAD) begin
                name = "mxu_activations";
            end else begin
                name = "fifo_out_data";
            end
            check_word($sformatf("%s in record %0d", name, r), observed, expected);
        end
        $display("TEST OK");
        $finish;
    end

endmodule

/* ls_array_input.txt */
// opcode (0 load, 1 store, 2 gather, 3 weight), precision (0 int8 to 3 int64), step count,
// data word or store base, expected last lane word, gathered word or weight address (hex)
0 3 9 a0 a8
0 2 1 b1 b1
0 0 3 c0 a4
0 1 1 d0 a5
1 3 1 1000 0
1 2 1 2000 0
2 3 5 0 1004
3 3 4 0 3
3 3 1 0 8
3 1 1a 0 3a
3 3 2 0 0
0 0 1 f0 f0

/* src.f */
+incdir+.
ls_pkg.sv
lane_enable_decoder.sv
slot_counter.sv
lane_load_bank.sv
result_bank.sv
weight_address_gen.sv
ls_array.sv
ls_array_properties.sv
tb_ls_array.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert -Wno-fatal --top-module tb_ls_array -f src.f
output=$(./obj_dir/Vtb_ls_array +verilator+error+limit+100 2>&1) || true
echo "$output"
echo "$output" | grep -qx "TEST OK"
